// ==== src/cache_defs.svh ====
// ------------------------------
// Cache geometry and field widths
// Two ways, 8 sets, 16-byte lines
// ------------------------------

`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

`define CACHE_ADDR_W      32
`define CACHE_DATA_W      32
`define CACHE_LINE_W      128
`define CACHE_LINE_WORDS  4
`define CACHE_SETS        8
`define CACHE_IDX_W       3   // log2 of sets
`define CACHE_OFS_W       4   // Byte offset in a line
`define CACHE_TAG_W       25  // Addr bits above index
`define CACHE_OPQ_W       8

`endif

// ==== src/cache_pkg.sv ====
// ------------------------------
// Cache types
// Controller states and request opcodes
// ------------------------------

package cache_pkg;

  typedef enum logic [3:0] {
    st_idle,
    st_tag_check,
    st_init_access,
    st_read_access,
    st_write_access,
    st_evict_prepare,
    st_evict_request,
    st_evict_wait,
    st_refill_request,
    st_refill_wait,
    st_refill_update,
    st_resp_wait
  } cache_state_e;

  typedef enum logic [2:0] {
    op_read  = 3'd0,
    op_write = 3'd1,
    op_init  = 3'd2   // Fill way 0, no memory traffic
  } cache_op_e;

  typedef enum logic [2:0] {
    mem_read  = 3'd0,
    mem_write = 3'd1
  } mem_op_e;

endpackage

// ==== src/cache_ifs.sv ====
// ------------------------------
// Cache internal interfaces
// Request, tag status and datapath control
// ------------------------------

`include "cache_defs.svh"

// Held request fields
interface cache_req_if import cache_pkg::*; ();
  logic [`CACHE_ADDR_W-1:0] addr;
  cache_op_e                op;
  logic [`CACHE_DATA_W-1:0] wdata;
  logic [`CACHE_OPQ_W-1:0]  opaque;

  modport src (output addr, op, wdata, opaque);
  modport dst (input addr, op, wdata, opaque);
endinterface

// Tag lookup results and update strobes
interface cache_tag_if ();
  logic                    match_0;
  logic                    match_1;
  logic                    valid_0;
  logic                    valid_1;
  logic                    dirty_0;
  logic                    dirty_1;
  logic                    lru;         // Way to replace next
  logic [`CACHE_TAG_W-1:0] victim_tag;
  logic                    update;
  logic                    update_way;
  logic                    set_dirty;
  logic                    set_lru_to;

  modport store (output match_0, match_1, valid_0, valid_1, dirty_0, dirty_1, lru, victim_tag,
                 input update, update_way, set_dirty, set_lru_to);
  modport ctrl (input match_0, match_1, valid_0, valid_1, dirty_0, dirty_1, lru,
                output update, update_way, set_dirty, set_lru_to);
  modport data (input victim_tag);
endinterface

// Data array control
interface cache_dp_if ();
  logic way;
  logic word_wen;    // Single word write
  logic line_fill;   // Whole line from memory
  logic resp_load;
  logic evict_load;  // High for the whole eviction

  modport ctrl (output way, word_wen, line_fill, resp_load, evict_load);
  modport data (input way, word_wen, line_fill, resp_load, evict_load);
endinterface

// ==== src/cache_req_in.sv ====
// ------------------------------
// Cache request capture
// Holds one request for a transaction
// ------------------------------

`include "cache_defs.svh"

module cache_req_in import cache_pkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     cachereq_val,
  input  logic                     cachereq_rdy,    // Controller is idle
  input  logic [`CACHE_ADDR_W-1:0] cachereq_addr,
  input  logic [`CACHE_DATA_W-1:0] cachereq_data,
  input  logic [`CACHE_OPQ_W-1:0]  cachereq_opaque,
  input  cache_op_e                cachereq_type,
  cache_req_if.src                 req
);

  logic accept;

  assign accept = cachereq_val && cachereq_rdy;

  // Fields seen on the response side
  always_ff @(posedge clk) begin
    if (reset) begin
      req.op     <= op_read;
      req.opaque <= '0;
    end else if (accept) begin
      req.op     <= cachereq_type;
      req.opaque <= cachereq_opaque;
    end
  end

  // Address and write word
  always_ff @(posedge clk) begin
    if (accept) begin
      req.addr  <= cachereq_addr;
      req.wdata <= cachereq_data;
    end
  end

endmodule

// ==== src/cache_tag_store.sv ====
// ------------------------------
// Cache tag store
// Tags, valid, dirty and LRU bits per set
// ------------------------------

`include "cache_defs.svh"

module cache_tag_store import cache_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  cache_req_if.dst   req,
  cache_tag_if.store tags
);

  // ------------------------------
  // Storage
  // ------------------------------

  logic [`CACHE_TAG_W-1:0]     tag_mem [2][`CACHE_SETS];
  logic [1:0][`CACHE_SETS-1:0] valid_q;
  logic [1:0][`CACHE_SETS-1:0] dirty_q;
  logic [`CACHE_SETS-1:0]      lru_q;

  logic [`CACHE_IDX_W-1:0] idx;
  logic [`CACHE_TAG_W-1:0] req_tag;

  assign idx     = req.addr[`CACHE_OFS_W +: `CACHE_IDX_W];
  assign req_tag = req.addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];

  // ------------------------------
  // Lookup
  // ------------------------------

  assign tags.valid_0 = valid_q[0][idx];
  assign tags.valid_1 = valid_q[1][idx];
  assign tags.dirty_0 = dirty_q[0][idx];
  assign tags.dirty_1 = dirty_q[1][idx];
  assign tags.lru     = lru_q[idx];

  // A match needs a valid line
  assign tags.match_0 = valid_q[0][idx] && (tag_mem[0][idx] == req_tag);
  assign tags.match_1 = valid_q[1][idx] && (tag_mem[1][idx] == req_tag);

  assign tags.victim_tag = tag_mem[lru_q[idx]][idx];

  // ------------------------------
  // Update
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
      dirty_q <= '0;
      lru_q   <= '0;
    end else if (tags.update) begin
      valid_q[tags.update_way][idx] <= 1'b1;
      dirty_q[tags.update_way][idx] <= tags.set_dirty;
      lru_q[idx]                    <= tags.set_lru_to;
    end
  end

  // Tag words themselves
  always_ff @(posedge clk) begin
    if (tags.update) begin
      tag_mem[tags.update_way][idx] <= req_tag;
    end
  end

endmodule

// ==== src/cache_ctrl.sv ====
// ------------------------------
// Cache controller
// Sequences lookup, access, evict and refill
// ------------------------------

module cache_ctrl import cache_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  cache_req_if.dst  req,
  cache_tag_if.ctrl tags,
  cache_dp_if.ctrl  dp,
  input  logic      cachereq_val,
  output logic      cachereq_rdy,
  output logic      cacheresp_val,
  input  logic      cacheresp_rdy,
  output logic      cacheresp_hit,
  output logic      memreq_val,
  output mem_op_e   memreq_type,
  input  logic      memreq_rdy,
  input  logic      memresp_val,
  output logic      memresp_rdy
);

  cache_state_e state, state_next;
  logic         hit_q;
  logic         way_q;  // Way used for the whole transaction
  logic         hit;
  logic         lru_dirty;
  logic         cur_dirty;

  assign hit       = tags.match_0 || tags.match_1;
  assign lru_dirty = tags.lru ? (tags.valid_1 && tags.dirty_1) : (tags.valid_0 && tags.dirty_0);
  assign cur_dirty = way_q ? tags.dirty_1 : tags.dirty_0;

  // ------------------------------
  // State and tag check results
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      hit_q <= 1'b0;
      way_q <= 1'b0;
    end else begin
      state <= state_next;
      if (state == st_tag_check) begin
        hit_q <= (req.op != op_init) && hit;
        if (req.op == op_init || tags.match_0) way_q <= 1'b0;
        else if (tags.match_1)                 way_q <= 1'b1;
        else                                   way_q <= tags.lru;  // Miss, replace LRU
      end
    end
  end

  // ------------------------------
  // Next state
  // ------------------------------

  always_comb begin
    state_next = state;
    case (state)
      st_idle:           if (cachereq_val) state_next = st_tag_check;
      st_tag_check: begin
        if (req.op == op_init)        state_next = st_init_access;
        else if (hit && req.op == op_write) state_next = st_write_access;
        else if (hit)                 state_next = st_read_access;
        else if (lru_dirty)           state_next = st_evict_prepare;
        else                          state_next = st_refill_request;
      end
      st_init_access,
      st_read_access,
      st_write_access:   state_next = st_resp_wait;
      st_evict_prepare:  state_next = st_evict_request;
      st_evict_request:  if (memreq_rdy) state_next = st_evict_wait;
      st_evict_wait:     if (memresp_val) state_next = st_refill_request;
      st_refill_request: if (memreq_rdy) state_next = st_refill_wait;
      st_refill_wait:    if (memresp_val) state_next = st_refill_update;
      st_refill_update: begin
        if (req.op == op_write) state_next = st_write_access;
        else                    state_next = st_read_access;
      end
      st_resp_wait:      if (cacheresp_rdy) state_next = st_idle;
      default:           state_next = st_idle;
    endcase
  end

  // ------------------------------
  // Outputs
  // ------------------------------

  assign cachereq_rdy  = (state == st_idle);
  assign cacheresp_val = (state == st_resp_wait);
  assign cacheresp_hit = hit_q;
  assign memreq_val    = (state == st_evict_request) || (state == st_refill_request);
  assign memreq_type   = (state == st_evict_request) ? mem_write : mem_read;
  assign memresp_rdy   = (state == st_evict_wait) || (state == st_refill_wait);

  // Datapath strobes
  assign dp.way        = way_q;
  assign dp.word_wen   = (state == st_init_access) || (state == st_write_access);
  assign dp.line_fill  = (state == st_refill_wait) && memresp_val;  // Data only valid here
  assign dp.resp_load  = (state == st_init_access) || (state == st_read_access) ||
                         (state == st_write_access);
  assign dp.evict_load = (state == st_evict_prepare) || (state == st_evict_request) ||
                         (state == st_evict_wait);

  // Tag update on every access and after a refill
  assign tags.update     = dp.resp_load || (state == st_refill_update);
  assign tags.update_way = way_q;
  assign tags.set_lru_to = ~way_q;

  always_comb begin
    case (state)
      st_write_access: tags.set_dirty = 1'b1;
      st_read_access:  tags.set_dirty = cur_dirty;  // Keep what is there
      default:         tags.set_dirty = 1'b0;       // Init and fresh refill are clean
    endcase
  end

endmodule

// ==== src/cache_data_store.sv ====
// ------------------------------
// Cache data store
// Line storage, response word and victim data
// ------------------------------

`include "cache_defs.svh"

module cache_data_store import cache_pkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  cache_req_if.dst                 req,
  cache_tag_if.data                tags,
  cache_dp_if.data                 dp,
  input  logic [`CACHE_LINE_W-1:0] memresp_data,
  output logic [`CACHE_ADDR_W-1:0] memreq_addr,
  output logic [`CACHE_LINE_W-1:0] memreq_data,
  output logic [`CACHE_DATA_W-1:0] cacheresp_data
);

  localparam int WSEL_W = $clog2(`CACHE_LINE_WORDS);

  logic [`CACHE_LINE_W-1:0] lines [2][`CACHE_SETS];
  logic [`CACHE_IDX_W-1:0]  idx;
  logic [WSEL_W-1:0]        wsel;
  logic [`CACHE_LINE_W-1:0] cur_line;
  logic [`CACHE_LINE_W-1:0] wr_line;
  logic [`CACHE_LINE_W-1:0] fill_line;
  logic [`CACHE_LINE_W-1:0] evict_line_q;
  logic [`CACHE_ADDR_W-1:0] evict_addr_q;
  logic [`CACHE_DATA_W-1:0] resp_q;

  assign idx      = req.addr[`CACHE_OFS_W +: `CACHE_IDX_W];
  assign wsel     = req.addr[`CACHE_OFS_W-1 -: WSEL_W];
  assign cur_line = lines[dp.way][idx];

  // Word merge for writes, inits and write refills
  always_comb begin
    wr_line   = cur_line;
    fill_line = memresp_data;
    wr_line[wsel * `CACHE_DATA_W +: `CACHE_DATA_W] = req.wdata;
    if (req.op == op_write) begin
      fill_line[wsel * `CACHE_DATA_W +: `CACHE_DATA_W] = req.wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (dp.word_wen) begin
      lines[dp.way][idx] <= wr_line;
    end else if (dp.line_fill) begin
      lines[dp.way][idx] <= fill_line;
    end
  end

  // ------------------------------
  // Victim and response registers
  // ------------------------------

  always_ff @(posedge clk) begin
    if (dp.evict_load) begin
      evict_line_q <= cur_line;
      evict_addr_q <= {tags.victim_tag, idx, {`CACHE_OFS_W{1'b0}}};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      resp_q <= '0;
    end else if (dp.resp_load) begin
      // Only reads return data
      resp_q <= (req.op == op_read) ? cur_line[wsel * `CACHE_DATA_W +: `CACHE_DATA_W] : '0;
    end
  end

  assign memreq_addr    = dp.evict_load ? evict_addr_q
                                        : {req.addr[`CACHE_ADDR_W-1:`CACHE_OFS_W],
                                           {`CACHE_OFS_W{1'b0}}};
  assign memreq_data    = evict_line_q;
  assign cacheresp_data = resp_q;

endmodule

// ==== src/cache_top.sv ====
// ------------------------------
// Two-way write-back cache
// Blocking, 256 bytes, 16-byte lines
// ------------------------------

`include "cache_defs.svh"

module cache_top import cache_pkg::*; (
  input  logic                     clk,
  input  logic                     reset,

  // Cache request
  input  logic                     cachereq_val,
  output logic                     cachereq_rdy,
  input  cache_op_e                cachereq_type,
  input  logic [`CACHE_ADDR_W-1:0] cachereq_addr,
  input  logic [`CACHE_DATA_W-1:0] cachereq_data,
  input  logic [`CACHE_OPQ_W-1:0]  cachereq_opaque,

  // Cache response
  output logic                     cacheresp_val,
  input  logic                     cacheresp_rdy,
  output cache_op_e                cacheresp_type,
  output logic [`CACHE_DATA_W-1:0] cacheresp_data,
  output logic [`CACHE_OPQ_W-1:0]  cacheresp_opaque,
  output logic                     cacheresp_hit,

  // Memory request
  output logic                     memreq_val,
  input  logic                     memreq_rdy,
  output mem_op_e                  memreq_type,
  output logic [`CACHE_ADDR_W-1:0] memreq_addr,
  output logic [`CACHE_LINE_W-1:0] memreq_data,

  // Memory response
  input  logic                     memresp_val,
  output logic                     memresp_rdy,
  input  logic [`CACHE_LINE_W-1:0] memresp_data
);

  cache_req_if req_bus ();
  cache_tag_if tag_bus ();
  cache_dp_if  dp_bus ();

  assign cacheresp_type   = req_bus.op;
  assign cacheresp_opaque = req_bus.opaque;

  cache_req_in u_req_in (
    .clk, .reset, .cachereq_val, .cachereq_rdy, .cachereq_addr, .cachereq_data,
    .cachereq_opaque, .cachereq_type, .req(req_bus)
  );

  cache_tag_store u_tag_store (.clk, .reset, .req(req_bus), .tags(tag_bus));

  cache_ctrl u_ctrl (
    .clk, .reset, .req(req_bus), .tags(tag_bus), .dp(dp_bus),
    .cachereq_val, .cachereq_rdy, .cacheresp_val, .cacheresp_rdy, .cacheresp_hit,
    .memreq_val, .memreq_type, .memreq_rdy, .memresp_val, .memresp_rdy
  );

  cache_data_store u_data_store (
    .clk, .reset, .req(req_bus), .tags(tag_bus), .dp(dp_bus),
    .memresp_data, .memreq_addr, .memreq_data, .cacheresp_data
  );

endmodule

// ==== dv/cache_checker.sv ====
// ------------------------------
// Cache protocol assertions
// Bound to the cache top level
// ------------------------------

`include "cache_defs.svh"

module cache_checker import cache_pkg::*; (
  input logic                     clk,
  input logic                     reset,
  input logic                     cachereq_rdy,
  input logic                     cacheresp_val,
  input logic                     memreq_val,
  input logic                     memreq_rdy,
  input logic [`CACHE_ADDR_W-1:0] memreq_addr,
  input logic                     memresp_val,
  input logic                     memresp_rdy
);

  int fail_count = 0;  // Polled by the testbench

  // Only one transaction in flight
  idle_not_busy: assert property (@(posedge clk) disable iff (reset)
    !(cachereq_rdy && cacheresp_val))
    else begin
      $error("Request ready and response valid high together");
      fail_count++;
    end

  memreq_held: assert property (@(posedge clk) disable iff (reset)
    memreq_val && !memreq_rdy |=> memreq_val && $stable(memreq_addr))
    else begin
      $error("Memory request dropped or changed before it was taken");
      fail_count++;
    end

  // Wait opens only right after a memory request is taken
  memresp_rdy_opens: assert property (@(posedge clk) disable iff (reset)
    $rose(memresp_rdy) |-> $past(memreq_val && memreq_rdy))
    else begin
      $error("Memory response ready without a memory request taken");
      fail_count++;
    end

  memresp_rdy_closes: assert property (@(posedge clk) disable iff (reset)
    memresp_val && memresp_rdy |=> !memresp_rdy)
    else begin
      $error("Memory response ready still high after the response was taken");
      fail_count++;
    end

  quiet_in_reset: assert property (@(posedge clk)
    reset |=> !cacheresp_val && !memreq_val)
    else begin
      $error("Valid output high during reset");
      fail_count++;
    end

endmodule

bind cache_top cache_checker u_checker (
  .clk, .reset, .cachereq_rdy, .cacheresp_val, .memreq_val, .memreq_rdy,
  .memreq_addr, .memresp_val, .memresp_rdy
);

// ==== dv/cache_tb.sv ====
// ------------------------------
// Cache testbench
// Memory model, directed and random traffic
// ------------------------------

`include "cache_defs.svh"

module cache_tb import cache_pkg::*; ();

  localparam int n_random    = 40;
  localparam int total_reqs  = 16 + n_random;
  localparam int cycle_limit = 40 * total_reqs + 100;

  logic                     clk = 1'b0;
  logic                     reset;
  logic                     cachereq_val, cachereq_rdy;
  cache_op_e                cachereq_type;
  logic [`CACHE_ADDR_W-1:0] cachereq_addr;
  logic [`CACHE_DATA_W-1:0] cachereq_data;
  logic [`CACHE_OPQ_W-1:0]  cachereq_opaque;
  logic                     cacheresp_val, cacheresp_rdy, cacheresp_hit;
  cache_op_e                cacheresp_type;
  logic [`CACHE_DATA_W-1:0] cacheresp_data;
  logic [`CACHE_OPQ_W-1:0]  cacheresp_opaque;
  logic                     memreq_val, memreq_rdy;
  mem_op_e                  memreq_type;
  logic [`CACHE_ADDR_W-1:0] memreq_addr;
  logic [`CACHE_LINE_W-1:0] memreq_data;
  logic                     memresp_val, memresp_rdy;
  logic [`CACHE_LINE_W-1:0] memresp_data;

  integer      seed = 32'hed4d;
  logic [31:0] rnd;
  int          cycles = 0;

  // Reference state, word and line granularity
  logic [31:0]  shadow [logic [31:0]];
  logic [127:0] mem_lines [logic [31:0]];

  // Expected responses in request order
  string     exp_name [$];
  cache_op_e exp_op [$];
  logic [7:0]  exp_opq [$];
  logic [31:0] exp_data [$];
  int          exp_hit [$];   // -1 when not checked
  logic [7:0]  next_opq = 8'd0;

  logic        bp_on = 1'b0;
  int          mem_req_count = 0;
  int          mem_write_count = 0;
  logic [31:0] last_write_addr = '0;
  logic        mem_req_seen = 1'b0;
  logic        mem_resp_done = 1'b0;
  logic [31:0] mem_addr_q;
  mem_op_e     mem_type_q;
  int          mem_wait = 0;
  logic        held = 1'b0;
  logic [31:0] held_data;
  logic [7:0]  held_opq;

  logic [31:0] rnd_addr [n_random];
  cache_op_e   rnd_op [n_random];
  logic [31:0] rnd_data [n_random];

  cache_top uut (.*);

  always #20 clk = ~clk;

  // ------------------------------
  // Reference model
  // ------------------------------

  function automatic logic [31:0] mem_pattern(input logic [31:0] addr);
    return (addr * 32'h9e3779b1) ^ 32'h0badcafe;
  endfunction

  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    logic [31:0] key;
    key = {addr[31:2], 2'b00};
    if (shadow.exists(key)) return shadow[key];
    return mem_pattern(key);
  endfunction

  function automatic logic [127:0] mem_line(input logic [31:0] line_addr);
    logic [127:0] line;
    if (mem_lines.exists(line_addr)) return mem_lines[line_addr];
    for (int i = 0; i < 4; i++) line[i*32 +: 32] = mem_pattern(line_addr + 4 * i);
    return line;
  endfunction

  task automatic abort_run();
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      abort_run();
    end
  endtask

  // ------------------------------
  // Request side
  // ------------------------------

  task automatic send_req(input string name, input cache_op_e op, input logic [31:0] addr,
                          input logic [31:0] data, input int hit);
    @(negedge clk);
    cachereq_val    = 1'b1;
    cachereq_type   = op;
    cachereq_addr   = addr;
    cachereq_data   = data;
    cachereq_opaque = next_opq;
    @(posedge clk);
    while (!cachereq_rdy) @(posedge clk);
    exp_name.push_back(name);   // Taken on this edge
    exp_op.push_back(op);
    exp_opq.push_back(next_opq);
    exp_data.push_back(expected_word(addr));
    exp_hit.push_back(hit);
    if (op != op_read) shadow[{addr[31:2], 2'b00}] = data;
    next_opq = next_opq + 8'd1;
  endtask

  task automatic wait_responses();
    @(negedge clk);
    cachereq_val = 1'b0;
    while (exp_op.size() != 0) @(negedge clk);
  endtask

  // ------------------------------
  // Response compare
  // ------------------------------

  task automatic compare_resp();
    string       name;
    cache_op_e   op;
    logic [7:0]  opq;
    logic [31:0] data;
    int          hit;
    if (exp_op.size() == 0) begin
      $display("Response arrived with no request outstanding");
      abort_run();
    end else begin
      name = exp_name.pop_front();
      op   = exp_op.pop_front();
      opq  = exp_opq.pop_front();
      data = exp_data.pop_front();
      hit  = exp_hit.pop_front();
      check({name, " type"}, {29'd0, op}, {29'd0, cacheresp_type});
      check({name, " opaque"}, {24'd0, opq}, {24'd0, cacheresp_opaque});
      if (op == op_read) check({name, " data"}, data, cacheresp_data);
      if (hit >= 0) check({name, " hit"}, hit, {31'd0, cacheresp_hit});
    end
  endtask

  always @(posedge clk) begin
    if (reset) begin
      held = 1'b0;
    end else if (cacheresp_val) begin
      if (held) begin
        check("held data", held_data, cacheresp_data);
        check("held opaque", {24'd0, held_opq}, {24'd0, cacheresp_opaque});
      end
      if (cacheresp_rdy) begin
        compare_resp();
        held = 1'b0;
      end else begin
        held      = 1'b1;
        held_data = cacheresp_data;
        held_opq  = cacheresp_opaque;
      end
    end else if (held) begin
      $display("Response withdrawn before it was taken");
      abort_run();
    end
  end

  // ------------------------------
  // Memory model, 2-cycle latency
  // ------------------------------

  always @(posedge clk) begin
    if (!reset && memreq_val && memreq_rdy) begin
      mem_req_seen  = 1'b1;
      mem_addr_q    = memreq_addr;
      mem_type_q    = memreq_type;
      mem_req_count = mem_req_count + 1;
      if (memreq_type == mem_write) begin
        for (int i = 0; i < 4; i++)
          check("writeback word", expected_word(memreq_addr + 4 * i), memreq_data[i*32 +: 32]);
        mem_lines[memreq_addr] = memreq_data;
        mem_write_count = mem_write_count + 1;
        last_write_addr = memreq_addr;
      end
    end
    if (!reset && memresp_val && memresp_rdy) mem_resp_done = 1'b1;
  end

  // All random draws for ready signals happen here
  always @(negedge clk) begin
    if (reset) begin
      memreq_rdy    = 1'b0;
      memresp_val   = 1'b0;
      cacheresp_rdy = 1'b1;
    end else begin
      if (mem_resp_done) begin
        memresp_val   = 1'b0;
        mem_resp_done = 1'b0;
      end
      if (mem_req_seen) begin
        mem_req_seen = 1'b0;
        memresp_data = (mem_type_q == mem_read) ? mem_line(mem_addr_q) : '0;
        mem_wait     = 2;
      end
      if (mem_wait != 0) begin
        mem_wait = mem_wait - 1;
        if (mem_wait == 0) memresp_val = 1'b1;
      end
      rnd = $random(seed);
      memreq_rdy = (mem_wait == 0) && !memresp_val && (rnd[1:0] != 2'b00);
      rnd = $random(seed);
      cacheresp_rdy = !bp_on || rnd[0];
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (uut.u_checker.fail_count != 0) begin
      $display("Protocol assertion failed, see the error above");
      abort_run();
    end else if (cycles > cycle_limit) begin
      $display("Timeout, run did not finish within %0d cycles", cycle_limit);
      abort_run();
    end
  end

  // ------------------------------
  // Stimulus
  // ------------------------------

  initial begin
    int          writes_before;
    int          reqs_before;
    logic [31:0] r;
    reset           = 1'b1;
    cachereq_val    = 1'b0;
    cachereq_type   = op_read;
    cachereq_addr   = '0;
    cachereq_data   = '0;
    cachereq_opaque = '0;
    cacheresp_rdy   = 1'b1;
    memreq_rdy      = 1'b0;
    memresp_val     = 1'b0;
    memresp_data    = '0;

    // Random traffic on sets 3 to 6, four tags each
    for (int i = 0; i < n_random; i++) begin
      r           = $random(seed);
      rnd_addr[i] = {23'd0, r[1:0], 3'd3 + {1'b0, r[3:2]}, r[5:4], 2'b00};
      rnd_op[i]   = r[6] ? op_write : op_read;
      rnd_data[i] = $random(seed);
    end

    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Init a line in set 0, then read it back
    reqs_before = mem_req_count;
    for (int i = 0; i < 4; i++) send_req("init", op_init, 32'h100 + 4 * i, 32'hc0de0000 + i, -1);
    wait_responses();
    check("init memory requests", reqs_before, mem_req_count);
    for (int i = 0; i < 4; i++) send_req("init readback", op_read, 32'h100 + 4 * i, '0, 1);
    wait_responses();

    send_req("read miss", op_read, 32'h214, '0, 0);
    send_req("read hit", op_read, 32'h214, '0, 1);
    wait_responses();

    writes_before = mem_write_count;
    send_req("write hit", op_write, 32'h218, 32'h5eed1234, 1);
    send_req("read written", op_read, 32'h218, '0, 1);
    wait_responses();
    check("write hit memory writes", writes_before, mem_write_count);

    // Three tags on set 2, the dirty one goes out
    writes_before = mem_write_count;
    send_req("dirty write", op_write, 32'h024, 32'hd1f70001, 0);
    send_req("second line", op_read, 32'h0a4, '0, 0);
    send_req("third line", op_read, 32'h124, '0, 0);
    send_req("evicted line", op_read, 32'h024, '0, 0);
    wait_responses();
    check("eviction count", writes_before + 1, mem_write_count);
    check("eviction address", 32'h020, last_write_addr);

    @(posedge clk);
    bp_on = 1'b1;
    for (int i = 0; i < n_random; i++) send_req("random", rnd_op[i], rnd_addr[i], rnd_data[i], -1);
    wait_responses();

    if (uut.u_checker.fail_count == 0) begin
      $display("No errors");
      $finish;
    end else begin
      $display("Protocol assertions failed %0d times", uut.u_checker.fail_count);
      abort_run();
    end
  end

endmodule

// ==== build.f ====
+incdir+src
src/cache_pkg.sv
src/cache_ifs.sv
src/cache_req_in.sv
src/cache_tag_store.sv
src/cache_ctrl.sv
src/cache_data_store.sv
src/cache_top.sv
dv/cache_checker.sv
dv/cache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cache_tb
FLIST     ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
